// File: vid_consts.svh
// video fetch constants
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// video modes, low bits of the mode byte
`define VID_M_ZX 2'd0 // zx screen
`define VID_M_HC 2'd1 // 16 colours
`define VID_M_XC 2'd2 // 256 colours
`define VID_M_TX 2'd3 // text

// raster totals
`define VID_H_TOTAL    9'd448 // clocks per line
`define VID_V_TOTAL_50 9'd320 // lines per frame at 50 hz
`define VID_V_TOTAL_60 9'd262 // lines per frame at 60 hz

// fetch columns per active line
`define VID_COLS_ZX 8'd32
`define VID_COLS_HC 8'd80
`define VID_COLS_XC 8'd160
`define VID_COLS_TX 8'd92 // 23 groups of char/attr/glyph0/glyph1

// dram bandwidth class, total cycles in [4:3], needed cycles in [2:0]
`define VID_BW_ZX 5'b11_001 // 1 of 8
`define VID_BW_HC 5'b01_001 // 1 of 4
`define VID_BW_XC 5'b00_001 // 1 of 2
`define VID_BW_TX 5'b11_100 // 4 of 8

`define VID_FIFO_DEPTH 4 // request queue entries

`endif

// File: vid_pkg.sv
// video fetch types
`default_nettype none

package vid_pkg;

	// page byte plus mode byte fields
	typedef struct packed {
		logic [7:0] vpage; // video page
		logic [1:0] vmode; // zx / 16c / 256c / text
		logic [1:0] rres;  // raster resolution
		logic       v60hz; // 60 hz frame
	} vid_cfg_t;

	// decoded raster window and fetch pattern
	typedef struct packed {
		logic [8:0] vpix_beg;    // first active line
		logic [8:0] vpix_end;    // line after last active
		logic [8:0] hpix_beg;    // first pixel clock
		logic [7:0] cols;        // fetch columns per line
		logic [1:0] render_mode;
		logic [4:0] bw;          // total/need cycle class
		logic       tv_hires;
	} vid_mode_t;

	typedef struct packed {
		logic [8:0] row;        // active row, 0 at vpix_beg
		logic       active;     // line inside window
		logic       line_start; // one clock at hcount 0
	} vid_pos_t;

	// one dram word request
	typedef struct packed {
		logic [20:0] addr; // word address
		logic [1:0]  bsl;
		logic [3:0]  sel;
		logic [4:0]  bw;
	} vid_req_t;

	typedef struct packed {
		logic [15:0] data;
	} vid_rsp_t;

endpackage

`default_nettype wire

// File: vid_mode_dec.sv
// video mode decoder
`timescale 1ns/10ps
`default_nettype none

`include "vid_consts.svh"

module vid_mode_dec (
	input  wire vid_pkg::vid_cfg_t  cfg,
	output vid_pkg::vid_mode_t      mode
);

	logic [8:0] vbeg_50, vbeg_60; // window start per refresh rate
	logic [8:0] vend_50, vend_60;
	logic [8:0] hbeg;

	// raster window, indexed by resolution
	always_comb begin
		case (cfg.rres)
			2'd0: begin // 256x192
				vbeg_50 = 9'd80;
				vend_50 = 9'd272;
				vbeg_60 = 9'd46;
				vend_60 = 9'd238;
				hbeg    = 9'd140; // 52 clocks of border each side
			end
			2'd1: begin // 320x200
				vbeg_50 = 9'd76;
				vend_50 = 9'd276;
				vbeg_60 = 9'd42;
				vend_60 = 9'd242;
				hbeg    = 9'd108;
			end
			2'd2: begin // 320x240
				vbeg_50 = 9'd56;
				vend_50 = 9'd296;
				vbeg_60 = 9'd22;
				vend_60 = 9'd262;
				hbeg    = 9'd108;
			end
			default: begin // 360x288, 240 lines at 60 hz
				vbeg_50 = 9'd32;
				vend_50 = 9'd320;
				vbeg_60 = 9'd22;
				vend_60 = 9'd262;
				hbeg    = 9'd88; // no side border
			end
		endcase
	end

	// fetch pattern, indexed by video mode
	always_comb begin
		mode.vpix_beg = cfg.v60hz ? vbeg_60 : vbeg_50;
		mode.vpix_end = cfg.v60hz ? vend_60 : vend_50;
		mode.hpix_beg = hbeg;
		mode.tv_hires = 1'b0;
		case (cfg.vmode)
			`VID_M_ZX: begin
				mode.cols        = `VID_COLS_ZX; // gfx/attr pairs
				mode.render_mode = `VID_M_ZX;
				mode.bw          = `VID_BW_ZX;
			end
			`VID_M_HC: begin
				mode.cols        = `VID_COLS_HC;
				mode.render_mode = `VID_M_HC;
				mode.bw          = `VID_BW_HC;
			end
			`VID_M_XC: begin
				mode.cols        = `VID_COLS_XC;
				mode.render_mode = `VID_M_XC;
				mode.bw          = `VID_BW_XC;
			end
			default: begin
				mode.cols        = `VID_COLS_TX;
				mode.render_mode = `VID_M_TX;
				mode.bw          = `VID_BW_TX;
				mode.tv_hires    = 1'b1; // only text runs at the fast pixel rate
			end
		endcase
	end

endmodule

`default_nettype wire

// File: vid_raster.sv
// raster line and frame counters
`timescale 1ns/10ps
`default_nettype none

`include "vid_consts.svh"

module vid_raster (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     v60hz,
	input  wire vid_pkg::vid_mode_t mode,
	output vid_pkg::vid_pos_t       pos,
	output logic                    frame_start
);

	logic [8:0] hcnt; // clock within line
	logic [8:0] vcnt; // line within frame
	logic [8:0] v_total;
	logic       h_last;
	logic       v_last;

	assign v_total = v60hz ? `VID_V_TOTAL_60 : `VID_V_TOTAL_50;
	assign h_last  = hcnt == `VID_H_TOTAL - 9'd1;
	assign v_last  = vcnt == v_total - 9'd1;

	// horizontal count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcnt <= '0;
		end else if (h_last) begin
			hcnt <= '0;
		end else begin
			hcnt <= hcnt + 9'd1;
		end
	end

	// vertical count steps as the line wraps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vcnt <= '0;
		end else if (h_last) begin
			if (v_last) begin
				vcnt <= '0; // next frame
			end else begin
				vcnt <= vcnt + 9'd1;
			end
		end
	end

	// position seen by the sequencer
	always_comb begin
		pos.line_start = hcnt == 9'd0;
		// window includes vpix_beg, excludes vpix_end
		pos.active     = (vcnt >= mode.vpix_beg) && (vcnt < mode.vpix_end);
		pos.row        = vcnt - mode.vpix_beg; // only meaningful when active
	end

	assign frame_start = pos.line_start && (vcnt == 9'd0); // first clock of line 0

endmodule

`default_nettype wire

// File: vid_fetch.sv
// per-line video fetch sequencer
`timescale 1ns/10ps
`default_nettype none

`include "vid_consts.svh"

module vid_fetch (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire vid_pkg::vid_cfg_t  cfg,
	input  wire vid_pkg::vid_mode_t mode,
	input  wire vid_pkg::vid_pos_t  pos,
	output logic                    req_valid,
	output vid_pkg::vid_req_t       req,
	input  wire                     req_ready,
	input  wire                     rsp_valid,
	input  wire vid_pkg::vid_rsp_t  rsp
);

	logic        busy;    // line in progress
	logic [7:0]  col;     // fetch column
	logic [8:0]  row_q;   // row latched at line start
	logic [15:0] char_q;  // last char codes, two per word
	logic        char_ok; // char word of this group arrived
	logic [1:0]  rsp_ph;  // text phase of the next response
	logic        is_text;
	logic [1:0]  ph;      // text phase of this column
	logic        glyph_wait;
	logic        xfer;
	logic        last_col;

	assign is_text    = cfg.vmode == `VID_M_TX;
	assign ph         = col[1:0];
	assign glyph_wait = is_text && (ph == 2'd2) && !char_ok; // hold glyph0
	assign req_valid  = busy && !glyph_wait;
	assign xfer       = req_valid && req_ready;
	assign last_col   = col == mode.cols - 8'd1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			col     <= '0;
			char_ok <= 1'b0;
			rsp_ph  <= '0;
		end else begin
			if (pos.line_start && pos.active) begin
				busy <= 1'b1;
				col  <= '0;
			end else if (xfer) begin
				if (last_col) begin
					busy <= 1'b0;
				end else begin
					col <= col + 8'd1;
				end
			end
			// responses come back in order, four per text group
			if (rsp_valid) begin
				rsp_ph <= rsp_ph + 2'd1;
			end
			if (xfer && is_text && (ph == 2'd3)) begin
				char_ok <= 1'b0; // group done with the char word
			end
			if (rsp_valid && is_text && (rsp_ph == 2'd0)) begin
				char_ok <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pos.line_start && pos.active && !busy) begin
			row_q <= pos.row;
		end
		if (rsp_valid && is_text && (rsp_ph == 2'd0)) begin
			char_q <= rsp.data;
		end
	end

	// address, byte lanes and selects per mode
	always_comb begin
		req.bw  = mode.bw;
		req.bsl = 2'b10;
		case (cfg.vmode)
			`VID_M_ZX: begin
				req.sel = {~col[0], ~col[0], col[0], col[0]};
				if (col[0]) begin // attribute
					req.addr = {cfg.vpage, 1'b0, 3'b110, row_q[7:3], col[4:1]};
				end else begin // pixels, zx line interleave
					req.addr = {cfg.vpage, 1'b0, row_q[7:6], row_q[2:0], row_q[5:3],
						col[4:1]};
				end
			end
			`VID_M_HC: begin
				req.sel  = {~col[0], ~col[0], 2'b11};
				req.addr = {cfg.vpage[7:3], row_q, col[6:0]};
			end
			`VID_M_XC: begin
				req.sel  = {~col[0], ~col[0], 2'b11};
				req.addr = {cfg.vpage[7:4], row_q, col[7:0]};
			end
			default: begin
				case (ph)
					2'd0: begin // char
						req.sel  = 4'b0011;
						req.addr = {cfg.vpage, row_q[8:3], 1'b0, col[7:2]};
					end
					2'd1: begin // attr
						req.sel  = 4'b1100;
						req.addr = {cfg.vpage, row_q[8:3], 1'b1, col[7:2]};
					end
					2'd2: begin // glyph of the low char
						req.sel  = 4'b0001;
						req.bsl  = {2{row_q[0]}};
						req.addr = {cfg.vpage[7:1], ~cfg.vpage[0], 3'b000, char_q[7:0],
							row_q[2:1]};
					end
					default: begin // glyph of the high char
						req.sel  = 4'b0010;
						req.bsl  = {2{row_q[0]}};
						req.addr = {cfg.vpage[7:1], ~cfg.vpage[0], 3'b000, char_q[15:8],
							row_q[2:1]};
					end
				endcase
			end
		endcase
	end

	// stalled request keeps its payload
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable(req));

	// line must be fully issued before the raster starts the next one
	a_line_done: assert property (@(posedge clk) disable iff (!rst_n)
		pos.line_start |-> !busy);

endmodule

`default_nettype wire

// File: vid_req_fifo.sv
// dram request queue
`timescale 1ns/10ps
`default_nettype none

module vid_req_fifo #(
	parameter int DEPTH = 4
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire vid_pkg::vid_req_t in_data,
	output logic                   out_valid,
	input  wire                    out_ready,
	output vid_pkg::vid_req_t      out_data
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	vid_pkg::vid_req_t mem [DEPTH]; // payload store
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count; // entries held
	logic          push;
	logic          pop;

	assign in_ready  = count != (AW+1)'(DEPTH); // full drops ready
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// occupancy never exceeds the depth nor wraps below empty
	a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (AW+1)'(DEPTH));

	// pointer distance tracks the occupancy
	a_ptr_gap: assert property (@(posedge clk) disable iff (!rst_n)
		(int'(rd_ptr) + int'(count)) % DEPTH == int'(wr_ptr));

	// head entry holds until the dram side takes it
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: vid_top.sv
// video fetch front end
`timescale 1ns/10ps
`default_nettype none

`include "vid_consts.svh"

module vid_top (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire vid_pkg::vid_cfg_t cfg,
	output logic                   dram_req_valid,
	input  wire                    dram_req_ready,
	output vid_pkg::vid_req_t      dram_req,
	input  wire                    dram_rsp_valid,
	input  wire vid_pkg::vid_rsp_t dram_rsp,
	output logic                   frame_start
);

	vid_pkg::vid_mode_t mode; // decoded mode
	vid_pkg::vid_pos_t  pos;  // raster position
	vid_pkg::vid_req_t  req;  // sequencer to queue
	logic               req_valid;
	logic               req_ready;

	vid_mode_dec i_mode_dec (
		.cfg  (cfg),
		.mode (mode)
	);

	vid_raster i_raster (
		.clk         (clk),
		.rst_n       (rst_n),
		.v60hz       (cfg.v60hz),
		.mode        (mode),
		.pos         (pos),
		.frame_start (frame_start)
	);

	vid_fetch i_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.mode      (mode),
		.pos       (pos),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (dram_rsp_valid), // responses go straight to the sequencer
		.rsp       (dram_rsp)
	);

	vid_req_fifo #(
		.DEPTH (`VID_FIFO_DEPTH)
	) i_req_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.in_data   (req),
		.out_valid (dram_req_valid),
		.out_ready (dram_req_ready),
		.out_data  (dram_req)
	);

endmodule

`default_nettype wire

// File: tb_vid_top.sv
// video fetch testbench
`timescale 1ns/10ps
`default_nettype none

`include "vid_consts.svh"

module tb_vid_top;

	logic              clk;
	logic              rst_n;
	vid_pkg::vid_cfg_t cur_cfg;
	logic              dram_req_valid;
	logic              dram_req_ready;
	vid_pkg::vid_req_t dram_req;
	logic              dram_rsp_valid;
	vid_pkg::vid_rsp_t dram_rsp;
	logic              frame_start;

	int                cyc;        // edges since reset release
	logic              rand_ready; // random back-pressure
	int                cols;
	int                win_beg;
	int                rows;
	int                exp_idx;    // next expected request
	int                rows_seen;
	int                row_i;
	int                col_i;
	logic [15:0]       last_char;  // data of the last char request
	vid_pkg::vid_req_t exp_req;
	logic [31:0]       rng;
	logic [31:0]       rsp_word;
	logic [20:0]       rsp_addr_q[$]; // dram model, in order
	int                rsp_due_q[$];
	int                edge_cyc;
	logic              edge_rand;
	logic              toggle;

	vid_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg            (cur_cfg),
		.dram_req_valid (dram_req_valid),
		.dram_req_ready (dram_req_ready),
		.dram_req       (dram_req),
		.dram_rsp_valid (dram_rsp_valid),
		.dram_rsp       (dram_rsp),
		.frame_start    (frame_start)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int window_edge(input logic [1:0] rres, input logic v60,
		input logic last);
		case (rres)
			2'd0: return last ? (v60 ? 238 : 272) : (v60 ? 46 : 80);
			2'd1: return last ? (v60 ? 242 : 276) : (v60 ? 42 : 76);
			2'd2: return last ? (v60 ? 262 : 296) : (v60 ? 22 : 56);
			default: return last ? (v60 ? 262 : 320) : (v60 ? 22 : 32);
		endcase
	endfunction

	// expected request for one fetch column
	function automatic vid_pkg::vid_req_t expect_req(input vid_pkg::vid_cfg_t c,
		input logic [8:0] row, input logic [7:0] col, input logic [15:0] chr);
		vid_pkg::vid_req_t r;
		r.bsl = 2'b10;
		r.sel = col[0] ? 4'b0011 : 4'b1111; // word lanes for 16c/256c
		case (c.vmode)
			`VID_M_ZX: begin
				r.bw  = `VID_BW_ZX;
				r.sel = col[0] ? 4'b0011 : 4'b1100;
				r.addr = col[0] ? {c.vpage, 1'b0, 3'b110, row[7:3], col[4:1]}
					: {c.vpage, 1'b0, row[7:6], row[2:0], row[5:3], col[4:1]};
			end
			`VID_M_HC: begin
				r.bw   = `VID_BW_HC;
				r.addr = {c.vpage[7:3], row, col[6:0]};
			end
			`VID_M_XC: begin
				r.bw   = `VID_BW_XC;
				r.addr = {c.vpage[7:4], row, col[7:0]};
			end
			default: begin
				r.bw  = `VID_BW_TX;
				case (col[1:0])
					2'd0: r.sel = 4'b0011;    // char
					2'd1: r.sel = 4'b1100;    // attr
					2'd2: r.sel = 4'b0001;    // glyph0
					default: r.sel = 4'b0010; // glyph1
				endcase
				r.addr = {c.vpage, row[8:3], col[0], col[7:2]};
				if (col[1]) begin // glyph words
					r.bsl  = {2{row[0]}};
					r.addr = {c.vpage[7:1], ~c.vpage[0], 3'b000,
						col[0] ? chr[15:8] : chr[7:0], row[2:1]};
				end
			end
		endcase
		return r;
	endfunction

	task automatic fail_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_text(input string why);
		$display("%0t %s", $time, why);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) cyc <= 0;
		else cyc <= cyc + 1;
	end

	// dram model, ready pattern and in-order responses 2 to 5 cycles late
	always @(posedge clk) begin
		edge_cyc  = cyc;
		edge_rand = rand_ready;
		if (!rst_n) begin
			rsp_addr_q.delete();
			rsp_due_q.delete();
		end else if (dram_req_valid && dram_req_ready) begin
			rng = xorshift32(rng);
			rsp_addr_q.push_back(dram_req.addr);
			rsp_due_q.push_back(edge_cyc + 2 + int'(rng[1:0]));
		end
		#2;
		rng            = xorshift32(rng);
		toggle         = ~toggle;
		dram_req_ready = !edge_rand || toggle || rng[0]; // high every other cycle
		dram_rsp_valid = 1'b0;
		if (rsp_addr_q.size() > 0 && rsp_due_q[0] <= edge_cyc + 1) begin
			rsp_word       = xorshift32({11'd0, rsp_addr_q.pop_front()});
			dram_rsp.data  = rsp_word[15:0];
			dram_rsp_valid = 1'b1;
			void'(rsp_due_q.pop_front());
		end
	end

	// checker of every transfer on the dram port
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_idx   = 0;
			rows_seen = 0;
			last_char = '0;
		end else begin
			assert (!(dram_req_valid && cyc <= win_beg * int'(`VID_H_TOTAL)))
			else fail_text("dram_req_valid rose before the first active line");
			if (dram_req_valid && dram_req_ready) begin
				row_i = exp_idx / cols;
				col_i = exp_idx % cols;
				assert (row_i < rows)
				else fail_text("more requests than the frame window holds");
				if (col_i == 0) begin // row starts on its own line
					assert (cyc / int'(`VID_H_TOTAL) == win_beg + row_i)
					else fail_value("line of row start", 64'(cyc / int'(`VID_H_TOTAL)),
						64'(win_beg + row_i));
					rows_seen = rows_seen + 1;
				end
				exp_req = expect_req(cur_cfg, 9'(row_i), 8'(col_i), last_char);
				assert (dram_req === exp_req)
				else fail_value("dram_req", 64'(dram_req), 64'(exp_req));
				if (cur_cfg.vmode == `VID_M_TX && col_i % 4 == 0) begin
					rsp_word  = xorshift32({11'd0, exp_req.addr});
					last_char = rsp_word[15:0]; // what the model returns for this char word
				end
				exp_idx = exp_idx + 1;
			end
		end
	end

	// one frame from reset to the next frame_start
	task automatic run_frame(input logic [1:0] vmode, input logic [1:0] rres,
		input logic v60, input logic rnd);
		int n;
		@(posedge clk);
		#2;
		rst_n         = 1'b0;
		cur_cfg.vpage = {4'ha, rres, vmode};
		cur_cfg.vmode = vmode;
		cur_cfg.rres  = rres;
		cur_cfg.v60hz = v60;
		rand_ready    = rnd;
		cols          = (vmode == `VID_M_ZX) ? 32 : (vmode == `VID_M_HC) ? 80
			: (vmode == `VID_M_XC) ? 160 : 92;
		win_beg       = window_edge(rres, v60, 1'b0);
		rows          = window_edge(rres, v60, 1'b1) - win_beg;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		n     = 0;
		do begin
			@(posedge clk);
			n = n + 1;
			if (n > 322 * 448) fail_text("no frame_start within a frame time");
		end while (!(frame_start && cyc > 0));
		assert (cyc == (v60 ? 262 : 320) * 448)
		else fail_value("frame_start cycle", 64'(cyc), 64'((v60 ? 262 : 320) * 448));
		n = 0;
		while (rsp_addr_q.size() > 0) begin // let the last responses drain
			@(negedge clk);
			n = n + 1;
			if (n > 16) fail_text("dram responses still pending after the frame");
		end
		assert (exp_idx == cols * rows)
		else fail_value("request count", 64'(exp_idx), 64'(cols * rows));
		assert (rows_seen == rows)
		else fail_value("active rows", 64'(rows_seen), 64'(rows));
	endtask

	initial begin
		rst_n          = 1'b0;
		cur_cfg        = '0;
		dram_req_ready = 1'b0;
		dram_rsp_valid = 1'b0;
		dram_rsp       = '0;
		rand_ready     = 1'b0;
		toggle         = 1'b0;
		rng            = 32'd35775;
		cols           = 32;
		win_beg        = 0;
		rows           = 0;
		run_frame(`VID_M_ZX, 2'd0, 1'b0, 1'b0); // ready always high
		run_frame(`VID_M_ZX, 2'd0, 1'b0, 1'b1); // same frame under back-pressure
		run_frame(`VID_M_HC, 2'd1, 1'b0, 1'b1);
		run_frame(`VID_M_XC, 2'd2, 1'b0, 1'b1);
		run_frame(`VID_M_TX, 2'd3, 1'b0, 1'b1);
		run_frame(`VID_M_ZX, 2'd0, 1'b1, 1'b1); // 60 hz windows, every rres
		run_frame(`VID_M_HC, 2'd1, 1'b1, 1'b1);
		run_frame(`VID_M_XC, 2'd2, 1'b1, 1'b0);
		run_frame(`VID_M_TX, 2'd3, 1'b1, 1'b1);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vid.f
+incdir+.
vid_pkg.sv
vid_mode_dec.sv
vid_raster.sv
vid_fetch.sv
vid_req_fifo.sv
vid_top.sv
tb_vid_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vid_top
FILELIST  ?= vid.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SRCS      ?= $(wildcard *.sv *.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
